/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing
LINTFLAGS := --lint-only --timing
TOP       := l1_cache_tb
RTL_TOP   := l1_cache
FILELIST  := l1_cache.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/l1_cache_mem.sv */
/*
 * Block-wide memory model for the L1 cache, one block per handshake.
 * Addresses at or above NONCACHE_START move one word, word 0 of the bus.
 * Byte enables are not applied, the cache zeroes disabled lanes itself.
 * Unwritten words read as their address xor 32'h5A5A_5A5A.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_mem import l1_cache_pkg::*; #(
    parameter int MAX_WAIT = 3
) (
    input  logic   CLK,
    input  logic   nRST,
    input  logic   mem_ren,
    input  logic   mem_wen,
    input  word_t  mem_addr,
    input  block_t mem_wdata,
    output block_t mem_rdata,
    output logic   mem_wait
);
    word_t       store [word_t];
    int unsigned remaining = 0;

    initial begin
        void'($urandom(32'h7aea));
    end

    // direct look at the contents, also used by the testbench
    function automatic word_t peek_word(input word_t addr);
        word_t a;
        a = {addr[WORD_W-1:2], 2'b00};
        if (store.exists(a)) begin
            return store[a];
        end
        return a ^ 32'h5A5A_5A5A;
    endfunction

    task automatic write_transfer(input word_t addr, input block_t data);
        word_t a;
        a = {addr[WORD_W-1:2], 2'b00};
        if (addr >= NONCACHE_START) begin
            store[a] = data[0];
        end else begin
            for (int i = 0; i < BLOCK_WORDS; i++) begin
                store[word_t'(a + 4 * i)] = data[i];
            end
        end
    endtask

    always_comb begin
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            mem_rdata[i] = peek_word(word_t'(mem_addr + 4 * i));
        end
    end

    // remaining holds the wait of the transfer now on the bus
    assign mem_wait = (mem_ren || mem_wen) && (remaining != 0);

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            remaining <= 0;
        end else if (mem_ren || mem_wen) begin
            if (remaining != 0) begin
                remaining <= remaining - 1;
            end else begin
                if (mem_wen) begin
                    write_transfer(mem_addr, mem_wdata);
                end
                remaining <= $urandom % (MAX_WAIT + 1);
            end
        end
    end
endmodule

`default_nettype wire

/* bench/l1_cache_tb.sv */
/*
 * Trace-driven testbench for the L1 cache.
 * Each trace line is op, address, wdata, byte_en, expected, all in hex.
 * Inputs change 1 ns after the rising edge, outputs are sampled at the falling edge.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_tb import l1_cache_pkg::*; ();
    localparam int MAX_OPS      = 64;
    localparam int FIELDS       = 5;
    localparam int MAX_WAIT     = 3;
    localparam int RESET_CYCLES = 5;
    // a flush with every set dirty is the slowest operation
    localparam int OP_CYCLES    = N_SETS * (MAX_WAIT + 1) + 8;

    localparam logic [31:0] OP_READ   = 32'd1;
    localparam logic [31:0] OP_WRITE  = 32'd2;
    localparam logic [31:0] OP_FLUSH  = 32'd3;
    localparam logic [31:0] OP_MEMCHK = 32'd4;

    logic       CLK = 1'b0;
    logic       nRST;
    logic       flush;
    logic       flush_done;
    logic       proc_ren;
    logic       proc_wen;
    word_t      proc_addr;
    word_t      proc_wdata;
    logic [3:0] proc_byte_en;
    word_t      proc_rdata;
    logic       proc_busy;
    logic       mem_ren;
    logic       mem_wen;
    word_t      mem_addr;
    block_t     mem_wdata;
    logic [3:0] mem_byte_en;
    block_t     mem_rdata;
    logic       mem_wait;

    logic [31:0] trace [MAX_OPS * FIELDS];
    int          n_ops = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000;

    l1_cache dut_i (
        .CLK(CLK), .nRST(nRST), .flush(flush), .flush_done(flush_done),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .proc_addr(proc_addr),
        .proc_wdata(proc_wdata), .proc_byte_en(proc_byte_en),
        .proc_rdata(proc_rdata), .proc_busy(proc_busy),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_byte_en(mem_byte_en),
        .mem_rdata(mem_rdata), .mem_wait(mem_wait)
    );

    l1_cache_mem #(.MAX_WAIT(MAX_WAIT)) mem_i (
        .CLK(CLK), .nRST(nRST), .mem_ren(mem_ren), .mem_wen(mem_wen),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata), .mem_wait(mem_wait)
    );

    always #50 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic check_value(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR @ %0t: %s got %h, expected %h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // byte lanes while a transfer is on the bus
    always @(negedge CLK) begin
        if (nRST && (mem_ren || mem_wen)) begin
            if (mem_addr < NONCACHE_START) begin
                check_value("mem_byte_en of a block transfer", 32'(mem_byte_en), 32'hF);
            end else if (mem_wen) begin
                check_value("mem_byte_en of an uncached store", 32'(mem_byte_en),
                            32'(proc_byte_en));
            end
        end
    end

    // request level stays up until busy is seen low
    task automatic wait_not_busy(output word_t rdata);
        @(negedge CLK);
        while (proc_busy) begin
            @(negedge CLK);
        end
        rdata = proc_rdata;
        @(posedge CLK);
        #1;
    endtask

    task automatic wait_flush_done();
        @(negedge CLK);
        while (!flush_done) begin
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
    endtask

    initial begin
        logic [31:0] op;
        word_t       addr;
        word_t       expected;
        word_t       rdata;

        nRST         = 1'b0;
        flush        = 1'b0;
        proc_ren     = 1'b0;
        proc_wen     = 1'b0;
        proc_addr    = '0;
        proc_wdata   = '0;
        proc_byte_en = 4'h0;

        for (int i = 0; i < MAX_OPS * FIELDS; i++) begin
            trace[i] = '0;
        end
        $readmemh("bench/l1_cache_trace.txt", trace);
        while (n_ops < MAX_OPS && trace[FIELDS * n_ops] != 0) begin
            n_ops++;
        end
        if (n_ops == 0) begin
            $display("the trace file bench/l1_cache_trace.txt is missing or empty");
            $display("Testbench failed");
            $fatal(1, "no stimulus");
        end
        cycle_limit = RESET_CYCLES + N_SETS + (n_ops + 1) * OP_CYCLES;

        repeat (RESET_CYCLES) @(posedge CLK);
        #1;
        nRST = 1'b1;
        @(negedge CLK);
        // clear sweep keeps the core stalled
        check_value("proc_busy after reset", 32'(proc_busy), 32'd1);
        check_value("mem_ren after reset", 32'(mem_ren), 32'd0);
        check_value("mem_wen after reset", 32'(mem_wen), 32'd0);
        check_value("flush_done after reset", 32'(flush_done), 32'd0);
        @(posedge CLK);
        #1;

        for (int i = 0; i < n_ops; i++) begin
            op       = trace[FIELDS * i];
            addr     = trace[FIELDS * i + 1];
            expected = trace[FIELDS * i + 4];
            case (op)
                OP_READ: begin
                    proc_ren  = 1'b1;
                    proc_addr = addr;
                    wait_not_busy(rdata);
                    proc_ren  = 1'b0;
                    check_value($sformatf("read of %h", addr), rdata, expected);
                end
                OP_WRITE: begin
                    proc_wen     = 1'b1;
                    proc_addr    = addr;
                    proc_wdata   = trace[FIELDS * i + 2];
                    proc_byte_en = trace[FIELDS * i + 3][3:0];
                    wait_not_busy(rdata);
                    proc_wen     = 1'b0;
                end
                OP_FLUSH: begin
                    flush = 1'b1;
                    @(posedge CLK);
                    #1;
                    flush = 1'b0;
                    wait_flush_done();
                end
                OP_MEMCHK: begin
                    check_value($sformatf("memory at %h", addr), mem_i.peek_word(addr),
                                expected);
                end
                default: begin
                    $display("trace line %0d holds an unknown operation %h", i, op);
                    $display("Testbench failed");
                    $fatal(1, "bad trace");
                end
            endcase
        end

        $display("Testbench passed");
        $finish;
    end
endmodule

`default_nettype wire

/* bench/l1_cache_trace.txt */
// op addr wdata byte_en expected, op 1 read, 2 write, 3 flush, 4 memory check
// unwritten memory reads as address xor 5A5A5A5A
1 00000040 00000000 0 5A5A5A1A
1 00000040 00000000 0 5A5A5A1A
1 00000044 00000000 0 5A5A5A1E
2 00000040 11223344 5 00000000
1 00000040 00000000 0 5A225A44
1 000000C0 00000000 0 5A5A5A9A
4 00000040 00000000 0 5A225A44
4 00000044 00000000 0 5A5A5A1E
1 00000040 00000000 0 5A225A44
2 F0000010 AABBCCDD 3 00000000
4 F0000010 00000000 0 0000CCDD
1 F0000010 00000000 0 0000CCDD
1 F0000020 00000000 0 AA5A5A7A
2 00000100 DEADBEEF F 00000000
2 00000108 01234567 F 00000000
2 000001FC CAFEF00D C 00000000
2 00000044 00000077 1 00000000
3 00000000 00000000 0 00000000
4 00000100 00000000 0 DEADBEEF
4 00000108 00000000 0 01234567
4 000001FC 00000000 0 CAFE5BA6
4 00000044 00000000 0 5A5A5A77
4 00000104 00000000 0 5A5A5B5E
1 00000100 00000000 0 DEADBEEF
1 000001FC 00000000 0 CAFE5BA6
1 00000044 00000000 0 5A5A5A77

/* l1_cache.f */
rtl/l1_cache_pkg.sv
rtl/frame_array.sv
rtl/tag_lookup.sv
rtl/store_merge.sv
rtl/flush_walker.sv
rtl/cache_ctrl.sv
rtl/l1_cache.sv
bench/l1_cache_mem.sv
bench/l1_cache_tb.sv

/* rtl/cache_ctrl.sv */
/*
 * Cache FSM. The core must hold its request level and address until busy drops.
 * A flush pulse is remembered until flush_done. An uncached access already on
 * the bus is allowed to finish before the flush starts.
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl import l1_cache_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       proc_ren,
    input  logic       proc_wen,
    input  logic       flush,
    input  logic       hit,
    input  logic       victim_dirty,
    input  logic       pass_through,
    input  logic       mem_wait,
    input  logic       walk_finish,
    input  tag_entry_t tag_rd,
    input  set_idx_t   walk_set,
    input  word_t      victim_addr,
    input  word_t      proc_addr,
    output logic       proc_busy,
    output logic       flush_done,
    output set_idx_t   arr_sel,
    output logic       arr_wen,
    output logic       fill,
    output tag_entry_t tag_wr,
    output logic       mem_ren,
    output logic       mem_wen,
    output word_t      mem_addr,
    output logic       walk_step,
    output logic       walk_clear
);
    typedef enum logic [2:0] {CLEAR, LOOKUP, FETCH, WB, FLUSH} state_t;

    state_t state;
    state_t next_state;
    logic   flush_req;
    logic   req;

    assign req = proc_ren || proc_wen;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= CLEAR;
            flush_req <= 1'b0;
        end else begin
            state     <= next_state;
            flush_req <= (flush_req || flush) && !flush_done;
        end
    end

    // the sweep states walk the sets, everything else follows the core address
    assign arr_sel = (state == CLEAR || state == FLUSH) ? walk_set
                                                         : proc_addr[WOFF_W+2 +: SET_W];

    always_comb begin
        next_state = state;
        proc_busy  = 1'b1;
        flush_done = 1'b0;
        arr_wen    = 1'b0;
        fill       = 1'b0;
        tag_wr     = '0;
        mem_ren    = 1'b0;
        mem_wen    = 1'b0;
        mem_addr   = '0;
        walk_step  = 1'b0;
        walk_clear = 1'b0;

        case (state)
            CLEAR: begin
                // invalidate one set per cycle
                arr_wen   = 1'b1;
                walk_step = 1'b1;
                if (walk_set == set_idx_t'(N_SETS - 1)) begin
                    walk_clear = 1'b1;
                    next_state = LOOKUP;
                end
            end
            LOOKUP: begin
                if (req && pass_through) begin
                    mem_ren   = proc_ren;
                    mem_wen   = proc_wen;
                    mem_addr  = proc_addr;
                    proc_busy = mem_wait;
                end else if (flush || flush_req) begin
                    next_state = FLUSH;
                end else if (req && hit) begin
                    proc_busy = 1'b0;
                    if (proc_wen) begin
                        arr_wen      = 1'b1;
                        tag_wr.valid = 1'b1;
                        tag_wr.dirty = 1'b1;
                        tag_wr.tag   = tag_rd.tag;
                    end
                end else if (req) begin
                    next_state = victim_dirty ? WB : FETCH;
                end
            end
            FETCH: begin
                mem_ren  = 1'b1;
                mem_addr = {proc_addr[WORD_W-1:WOFF_W+2], {(WOFF_W+2){1'b0}}};
                if (!mem_wait) begin
                    arr_wen      = 1'b1;
                    fill         = 1'b1;
                    tag_wr.valid = 1'b1;
                    // a write miss merges its bytes into the fill
                    tag_wr.dirty = proc_wen;
                    tag_wr.tag   = proc_addr[WORD_W-1 -: TAG_W];
                    next_state   = LOOKUP;
                end
            end
            WB: begin
                mem_wen  = 1'b1;
                mem_addr = victim_addr;
                if (!mem_wait) begin
                    // frame left invalid, the re-lookup then misses clean
                    arr_wen    = 1'b1;
                    next_state = LOOKUP;
                end
            end
            FLUSH: begin
                if (walk_finish) begin
                    flush_done = 1'b1;
                    walk_clear = 1'b1;
                    next_state = LOOKUP;
                end else if (victim_dirty) begin
                    mem_wen  = 1'b1;
                    mem_addr = {tag_rd.tag, walk_set, {WOFF_W{1'b0}}, 2'b00};
                    if (!mem_wait) begin
                        arr_wen   = 1'b1;
                        walk_step = 1'b1;
                    end
                end else begin
                    arr_wen   = 1'b1;
                    walk_step = 1'b1;
                end
            end
            default: begin
                next_state = CLEAR;
            end
        endcase
    end
endmodule

`default_nettype wire

/* rtl/flush_walker.sv */
/*
 * Set counter for the clear after reset and for flush.
 * finish rises on the step past the last set and holds until clear.
 * clear takes priority over step.
 */
`timescale 1ns/1ps
`default_nettype none

module flush_walker import l1_cache_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     step,
    input  logic     clear,
    output set_idx_t set,
    output logic     finish
);
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            set    <= '0;
            finish <= 1'b0;
        end else if (clear) begin
            set    <= '0;
            finish <= 1'b0;
        end else if (step) begin
            // wraps back to set 0 after the last one
            set <= set + 1'b1;
            if (set == set_idx_t'(N_SETS - 1)) begin
                finish <= 1'b1;
            end
        end
    end
endmodule

`default_nettype wire

/* rtl/frame_array.sv */
/*
 * One entry per set, read combinationally and written on the rising edge.
 * Reset clears every entry, so a cleared tag reads as invalid and clean.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_array import l1_cache_pkg::*; #(
    parameter type ENTRY_T = block_t
) (
    input  logic     CLK,
    input  logic     nRST,
    input  set_idx_t sel,
    input  logic     wen,
    input  ENTRY_T   wdata,
    output ENTRY_T   rdata
);
    ENTRY_T entries [N_SETS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < N_SETS; i++) begin
                entries[i] <= '0;
            end
        end else if (wen) begin
            entries[sel] <= wdata;
        end
    end

    assign rdata = entries[sel];
endmodule

`default_nettype wire

/* rtl/l1_cache.sv */
/*
 * Top of the L1 data cache, one block per memory handshake.
 * Uncached accesses use word 0 of mem_wdata and mem_rdata, with a word address.
 * Block transfers always drive mem_byte_en as all ones.
 */
`timescale 1ns/1ps
`default_nettype none

module l1_cache import l1_cache_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       flush,
    output logic       flush_done,
    input  logic       proc_ren,
    input  logic       proc_wen,
    input  word_t      proc_addr,
    input  word_t      proc_wdata,
    input  logic [3:0] proc_byte_en,
    output word_t      proc_rdata,
    output logic       proc_busy,
    output logic       mem_ren,
    output logic       mem_wen,
    output word_t      mem_addr,
    output block_t     mem_wdata,
    output logic [3:0] mem_byte_en,
    input  block_t     mem_rdata,
    input  logic       mem_wait
);
    set_idx_t   arr_sel;
    logic       arr_wen;
    logic       fill;
    tag_entry_t tag_wr;
    tag_entry_t tag_rd;
    block_t     data_rd;
    block_t     block_wr;
    logic       hit;
    logic       victim_dirty;
    logic       pass_through;
    word_t      rd_word;
    word_t      victim_addr;
    word_t      pt_store;
    set_idx_t   walk_set;
    logic       walk_finish;
    logic       walk_step;
    logic       walk_clear;
    logic [3:0] wr_byte_en;
    logic       pt_xfer;
    block_t     pt_block;

    // reads never merge bytes into a fill
    assign wr_byte_en = proc_wen ? proc_byte_en : 4'h0;

    // only uncached transfers carry an address in the uncached region
    assign pt_xfer = (mem_addr >= NONCACHE_START);

    always_comb begin
        pt_block    = data_rd;
        pt_block[0] = pt_store;
    end

    assign mem_wdata   = pt_xfer ? pt_block : data_rd;
    assign mem_byte_en = pt_xfer ? proc_byte_en : 4'hF;
    assign proc_rdata  = pass_through ? mem_rdata[0] : rd_word;

    cache_ctrl u_ctrl (
        .CLK(CLK), .nRST(nRST),
        .proc_ren(proc_ren), .proc_wen(proc_wen), .flush(flush),
        .hit(hit), .victim_dirty(victim_dirty), .pass_through(pass_through),
        .mem_wait(mem_wait), .walk_finish(walk_finish), .tag_rd(tag_rd),
        .walk_set(walk_set), .victim_addr(victim_addr), .proc_addr(proc_addr),
        .proc_busy(proc_busy), .flush_done(flush_done), .arr_sel(arr_sel),
        .arr_wen(arr_wen), .fill(fill), .tag_wr(tag_wr),
        .mem_ren(mem_ren), .mem_wen(mem_wen), .mem_addr(mem_addr),
        .walk_step(walk_step), .walk_clear(walk_clear)
    );

    frame_array #(.ENTRY_T(tag_entry_t)) tag_array (
        .CLK(CLK), .nRST(nRST), .sel(arr_sel), .wen(arr_wen),
        .wdata(tag_wr), .rdata(tag_rd)
    );

    frame_array #(.ENTRY_T(block_t)) data_array (
        .CLK(CLK), .nRST(nRST), .sel(arr_sel), .wen(arr_wen),
        .wdata(block_wr), .rdata(data_rd)
    );

    tag_lookup u_lookup (
        .addr(proc_addr), .tag_rd(tag_rd), .data_rd(data_rd),
        .hit(hit), .victim_dirty(victim_dirty), .pass_through(pass_through),
        .rd_word(rd_word), .victim_addr(victim_addr)
    );

    store_merge u_merge (
        .addr(proc_addr), .wdata(proc_wdata), .byte_en(wr_byte_en),
        .data_rd(data_rd), .fill_data(mem_rdata), .fill(fill),
        .block_wr(block_wr), .pt_store(pt_store)
    );

    flush_walker u_walker (
        .CLK(CLK), .nRST(nRST), .step(walk_step), .clear(walk_clear),
        .set(walk_set), .finish(walk_finish)
    );
endmodule

`default_nettype wire

/* rtl/l1_cache_pkg.sv */
/*
 * Geometry and shared types of the direct-mapped write-back L1 data cache.
 * One way, N_SETS frames of BLOCK_WORDS words each, 32-bit byte addresses.
 * Addresses at or above NONCACHE_START are never cached.
 */
`default_nettype none

package l1_cache_pkg;
    localparam int WORD_W      = 32;
    localparam int N_SETS      = 16;
    localparam int BLOCK_WORDS = 2;
    localparam int SET_W       = $clog2(N_SETS);
    localparam int WOFF_W      = $clog2(BLOCK_WORDS);
    // what is left after index, word offset and the two byte bits
    localparam int TAG_W       = WORD_W - SET_W - WOFF_W - 2;

    // start of the uncached region
    localparam logic [WORD_W-1:0] NONCACHE_START = 32'hF000_0000;

    typedef logic [WORD_W-1:0] word_t;

    // word 0 sits in the low bits
    typedef word_t [BLOCK_WORDS-1:0] block_t;

    typedef logic [SET_W-1:0] set_idx_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;
endpackage

`default_nettype wire

/* rtl/store_merge.sv */
/*
 * Builds the block written into the data array and the uncached store word.
 * Every byte lane with its enable set is replaced, in any combination.
 * The caller zeroes byte_en for reads so that a read fill passes memory data.
 */
`timescale 1ns/1ps
`default_nettype none

module store_merge import l1_cache_pkg::*; (
    input  word_t       addr,
    input  word_t       wdata,
    input  logic [3:0]  byte_en,
    input  block_t      data_rd,
    input  block_t      fill_data,
    input  logic        fill,
    output block_t      block_wr,
    output word_t       pt_store
);
    logic [WOFF_W-1:0] woff;
    block_t            base;
    word_t             old_word;
    word_t             new_word;

    assign woff = addr[2 +: WOFF_W];

    always_comb begin
        // a fill starts from memory data, a write hit from the stored block
        base     = fill ? fill_data : data_rd;
        old_word = base[woff];
        for (int b = 0; b < 4; b++) begin
            new_word[8*b +: 8] = byte_en[b] ? wdata[8*b +: 8] : old_word[8*b +: 8];
            // disabled lanes go out as zero on the uncached path
            pt_store[8*b +: 8] = byte_en[b] ? wdata[8*b +: 8] : 8'h00;
        end
        block_wr       = base;
        block_wr[woff] = new_word;
    end
endmodule

`default_nettype wire

/* rtl/tag_lookup.sv */
/*
 * Purely combinational address decode and tag compare.
 * victim_dirty looks only at the stored tag, so it also serves the flush sweep.
 * An uncached address never reports a hit.
 */
`timescale 1ns/1ps
`default_nettype none

module tag_lookup import l1_cache_pkg::*; (
    input  word_t      addr,
    input  tag_entry_t tag_rd,
    input  block_t     data_rd,
    output logic       hit,
    output logic       victim_dirty,
    output logic       pass_through,
    output word_t      rd_word,
    output word_t      victim_addr
);
    logic [TAG_W-1:0]  addr_tag;
    set_idx_t          addr_idx;
    logic [WOFF_W-1:0] addr_woff;

    // tag | index | word offset | byte offset
    assign addr_tag  = addr[WORD_W-1 -: TAG_W];
    assign addr_idx  = addr[WOFF_W+2 +: SET_W];
    assign addr_woff = addr[2 +: WOFF_W];

    assign pass_through = (addr >= NONCACHE_START);
    assign hit          = !pass_through && tag_rd.valid && (tag_rd.tag == addr_tag);
    assign victim_dirty = tag_rd.valid && tag_rd.dirty;

    assign rd_word = data_rd[addr_woff];

    // block address of whatever frame currently sits at this index
    assign victim_addr = {tag_rd.tag, addr_idx, {WOFF_W{1'b0}}, 2'b00};
endmodule

`default_nettype wire
